// ==== common/axis_cdc_pkg.sv ====
`default_nettype none

package axis_cdc_pkg;

  //////////////////////////////
  // fifo sizing
  //////////////////////////////

  // payload width, no width conversion
  localparam int DATA_WIDTH  = 72;
  // entries, power of two only
  localparam int FIFO_DEPTH  = 16;
  localparam int ADDR_WIDTH  = $clog2(FIFO_DEPTH);
  // extra msb tells a full lap from an empty one
  localparam int PTR_WIDTH   = ADDR_WIDTH + 1;
  // flops per synchronizer chain
  localparam int SYNC_STAGES = 2;

  //////////////////////////////
  // stream beat
  //////////////////////////////

  typedef struct packed {
    logic [DATA_WIDTH-1:0] tdata;
    logic                  tlast;
  } axis_beat_t;

  // binary to gray, one bit flips per increment
  function automatic logic [PTR_WIDTH-1:0] bin2gray(input logic [PTR_WIDTH-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

endpackage

`default_nettype wire

// ==== hw/cdc_sync.sv ====
`timescale 1ns/1ns
`default_nettype none

module cdc_sync #(
  parameter int               WIDTH       = 1,
  parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [WIDTH-1:0] d,
  output logic [WIDTH-1:0] q
);

  import axis_cdc_pkg::*;

  // flop chain in the destination domain
  logic [WIDTH-1:0] sync_q [SYNC_STAGES];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= RESET_VALUE;
      end
    end else begin
      // first stage may go metastable
      sync_q[0] <= d;
      // later stages give it time to settle
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // only the last stage is safe to use
  assign q = sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== axis_fifo_async/fifo_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module fifo_mem (
  // write port, slave clock domain
  input  logic                                wr_clk,
  input  logic                                wr_en,
  input  logic [axis_cdc_pkg::ADDR_WIDTH-1:0] wr_addr,
  input  axis_cdc_pkg::axis_beat_t            wr_beat,
  // read port, no clock
  input  logic [axis_cdc_pkg::ADDR_WIDTH-1:0] rd_addr,
  output axis_cdc_pkg::axis_beat_t            rd_beat
);

  import axis_cdc_pkg::*;

  //////////////////////////////
  // storage
  //////////////////////////////

  // one beat per entry, no reset on payload
  axis_beat_t mem [FIFO_DEPTH];

  // write on the slave clock edge of the transfer
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_beat;
    end
  end

  //////////////////////////////
  // read
  //////////////////////////////

  // combinational read, head beat falls through
  // entry under rd_addr is never rewritten while unread
  assign rd_beat = mem[rd_addr];

endmodule

`default_nettype wire

// ==== axis_fifo_async/fifo_wr_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module fifo_wr_ctrl (
  input  logic                                s_axis_clk,
  input  logic                                reset,
  // slave handshake
  input  logic                                s_axis_tvalid,
  output logic                                s_axis_tready,
  // read pointer seen in the write domain
  input  logic [axis_cdc_pkg::PTR_WIDTH-1:0]  rd_ptr_gray_sync,
  // memory write port
  output logic                                wr_en,
  output logic [axis_cdc_pkg::ADDR_WIDTH-1:0] wr_addr,
  // published to the read domain
  output logic [axis_cdc_pkg::PTR_WIDTH-1:0]  wr_ptr_gray
);

  import axis_cdc_pkg::*;

  logic [PTR_WIDTH-1:0] wr_ptr_bin;
  logic [PTR_WIDTH-1:0] wr_ptr_bin_next;
  logic [PTR_WIDTH-1:0] wr_ptr_gray_next;
  logic [PTR_WIDTH-1:0] rd_ptr_gray_lap;
  logic                 full;

  //////////////////////////////
  // pointer update
  //////////////////////////////

  // beat accepted on valid and ready
  assign wr_en = s_axis_tvalid & s_axis_tready;

  assign wr_ptr_bin_next  = wr_ptr_bin + PTR_WIDTH'(wr_en);
  assign wr_ptr_gray_next = bin2gray(wr_ptr_bin_next);

  // read pointer one lap back, in gray the top two bits flip
  assign rd_ptr_gray_lap = {~rd_ptr_gray_sync[PTR_WIDTH-1 -: 2],
                            rd_ptr_gray_sync[PTR_WIDTH-3:0]};

  always_ff @(posedge s_axis_clk) begin
    if (reset) begin
      wr_ptr_bin  <= '0;
      wr_ptr_gray <= '0;
      // held full so nothing is accepted in reset
      full        <= 1'b1;
    end else begin
      wr_ptr_bin  <= wr_ptr_bin_next;
      wr_ptr_gray <= wr_ptr_gray_next;
      // stale read pointer only makes this pessimistic
      full        <= (wr_ptr_gray_next == rd_ptr_gray_lap);
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign s_axis_tready = ~full;
  // wrap bit dropped for the memory
  assign wr_addr       = wr_ptr_bin[ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== axis_fifo_async/fifo_rd_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module fifo_rd_ctrl (
  input  logic                                m_axis_clk,
  input  logic                                m_reset,
  // master handshake
  input  logic                                m_axis_tready,
  output logic                                m_axis_tvalid,
  // write pointer seen in the read domain
  input  logic [axis_cdc_pkg::PTR_WIDTH-1:0]  wr_ptr_gray_sync,
  // memory read address
  output logic [axis_cdc_pkg::ADDR_WIDTH-1:0] rd_addr,
  // published to the write domain
  output logic [axis_cdc_pkg::PTR_WIDTH-1:0]  rd_ptr_gray
);

  import axis_cdc_pkg::*;

  logic [PTR_WIDTH-1:0] rd_ptr_bin;
  logic [PTR_WIDTH-1:0] rd_ptr_bin_next;
  logic                 rd_en;
  logic                 empty;

  //////////////////////////////
  // empty detection
  //////////////////////////////

  // both pointers equal including the wrap bit
  // in m_reset both sides sit at zero, so empty
  assign empty = (rd_ptr_gray == wr_ptr_gray_sync);

  // head beat is valid whenever something is stored
  assign m_axis_tvalid = ~empty;

  //////////////////////////////
  // pointer update
  //////////////////////////////

  // beat leaves on valid and ready
  assign rd_en = m_axis_tvalid & m_axis_tready;

  assign rd_ptr_bin_next = rd_ptr_bin + PTR_WIDTH'(rd_en);

  always_ff @(posedge m_axis_clk) begin
    if (m_reset) begin
      rd_ptr_bin  <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr_bin  <= rd_ptr_bin_next;
      // registered gray, glitch free for the synchronizer
      rd_ptr_gray <= bin2gray(rd_ptr_bin_next);
    end
  end

  // address holds while stalled, so the beat holds too
  assign rd_addr = rd_ptr_bin[ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== axis_fifo_async/axis_fifo_async.sv ====
`timescale 1ns/1ns
`default_nettype none

module axis_fifo_async (
  // clocks and reset
  input  logic                     s_axis_clk,
  input  logic                     m_axis_clk,
  input  logic                     reset,

  // slave stream, s_axis_clk domain
  input  logic                     s_axis_tvalid,
  output logic                     s_axis_tready,
  input  axis_cdc_pkg::axis_beat_t s_axis_beat,

  // master stream, m_axis_clk domain
  output logic                     m_axis_tvalid,
  input  logic                     m_axis_tready,
  output axis_cdc_pkg::axis_beat_t m_axis_beat
);

  import axis_cdc_pkg::*;

  // write domain
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [PTR_WIDTH-1:0]  wr_ptr_gray;
  logic [PTR_WIDTH-1:0]  rd_ptr_gray_sync;

  // read domain
  logic                  m_reset;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [PTR_WIDTH-1:0]  rd_ptr_gray;
  logic [PTR_WIDTH-1:0]  wr_ptr_gray_sync;

  //////////////////////////////
  // reset into read domain
  //////////////////////////////

  // asserts at once, release shifts through the chain
  cdc_sync #(
    .WIDTH       (1),
    .RESET_VALUE (1'b1)
  ) u_reset_sync (
    .clk   (m_axis_clk),
    .reset (reset),
    .d     (1'b0),
    .q     (m_reset)
  );

  //////////////////////////////
  // write side
  //////////////////////////////

  fifo_wr_ctrl u_wr_ctrl (
    .s_axis_clk       (s_axis_clk),
    .reset            (reset),
    .s_axis_tvalid    (s_axis_tvalid),
    .s_axis_tready    (s_axis_tready),
    .rd_ptr_gray_sync (rd_ptr_gray_sync),
    .wr_en            (wr_en),
    .wr_addr          (wr_addr),
    .wr_ptr_gray      (wr_ptr_gray)
  );

  // read pointer back into write domain
  cdc_sync #(
    .WIDTH       (PTR_WIDTH),
    .RESET_VALUE ('0)
  ) u_rd_ptr_sync (
    .clk   (s_axis_clk),
    .reset (reset),
    .d     (rd_ptr_gray),
    .q     (rd_ptr_gray_sync)
  );

  // payload goes straight into the memory
  fifo_mem u_mem (
    .wr_clk  (s_axis_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_beat (s_axis_beat),
    .rd_addr (rd_addr),
    .rd_beat (m_axis_beat)
  );

  //////////////////////////////
  // read side
  //////////////////////////////

  // write pointer into read domain
  cdc_sync #(
    .WIDTH       (PTR_WIDTH),
    .RESET_VALUE ('0)
  ) u_wr_ptr_sync (
    .clk   (m_axis_clk),
    .reset (m_reset),
    .d     (wr_ptr_gray),
    .q     (wr_ptr_gray_sync)
  );

  fifo_rd_ctrl u_rd_ctrl (
    .m_axis_clk       (m_axis_clk),
    .m_reset          (m_reset),
    .m_axis_tready    (m_axis_tready),
    .m_axis_tvalid    (m_axis_tvalid),
    .wr_ptr_gray_sync (wr_ptr_gray_sync),
    .rd_addr          (rd_addr),
    .rd_ptr_gray      (rd_ptr_gray)
  );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 40,
  parameter int OFFSET = 0
) (
  output logic clk
);

  // starts low, first rising edge at OFFSET plus half a period
  initial begin
    clk = 1'b0;
    #(OFFSET);
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_axis_fifo_async.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_axis_fifo_async;

  import axis_cdc_pkg::*;

  localparam int          S_PERIOD     = 40;
  localparam int          M_PERIOD     = 56;
  localparam int          M_OFFSET     = 13;
  localparam int          RESET_CYCLES = 16;
  localparam int unsigned SEED         = 32'h8a9499a9;
  localparam int          RANDOM_BEATS = 300;
  localparam int          FILL_BEATS   = 40;
  localparam int          FILL_CYCLES  = 40;
  localparam int          DRAIN_CYCLES = 8;
  // every beat may take 20 slow periods, plus the reset
  localparam int WATCHDOG_NS = (RANDOM_BEATS + FILL_BEATS) * 20 * M_PERIOD
                               + RESET_CYCLES * S_PERIOD;
  localparam int BEAT_BITS   = $bits(axis_beat_t);

  localparam logic [1:0] SINK_RANDOM = 2'd0;
  localparam logic [1:0] SINK_STALL  = 2'd1;
  localparam logic [1:0] SINK_READY  = 2'd2;

  logic       s_axis_clk;
  logic       m_axis_clk;
  logic       reset;
  logic       s_axis_tvalid = 1'b0;
  logic       s_axis_tready;
  axis_beat_t s_axis_beat   = '0;
  logic       m_axis_tvalid;
  logic       m_axis_tready = 1'b0;
  axis_beat_t m_axis_beat;

  // scoreboard, one entry per accepted beat
  axis_beat_t sb_q[$];
  int         accepted_count  = 0;
  int         delivered_count = 0;
  int         offered_count   = 0;
  int         offer_limit     = 0;
  logic       offer_dense     = 1'b0;
  logic       s_fire          = 1'b0;
  logic [1:0] sink_mode       = SINK_RANDOM;
  logic       drained         = 1'b0;
  axis_beat_t held_beat       = '0;
  int         m_edges         = 0;

  tb_clock_gen #(.PERIOD(S_PERIOD), .OFFSET(0)) u_s_clk (.clk(s_axis_clk));
  tb_clock_gen #(.PERIOD(M_PERIOD), .OFFSET(M_OFFSET)) u_m_clk (.clk(m_axis_clk));

  axis_fifo_async DUT (
    .s_axis_clk    (s_axis_clk),
    .m_axis_clk    (m_axis_clk),
    .reset         (reset),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_beat   (s_axis_beat),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_beat   (m_axis_beat)
  );

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_beat_mismatch(input string test_name,
                                      input logic [BEAT_BITS-1:0] expected,
                                      input logic [BEAT_BITS-1:0] actual);
    abort_run($sformatf("ERR %s expected %0h actual %0h", test_name, expected, actual));
  endtask

  task automatic report_count_mismatch(input string test_name, input int expected,
                                       input int actual);
    abort_run($sformatf("ERR %s expected %0d actual %0d", test_name, expected, actual));
  endtask

  // random payload, tlast on about one beat in eight
  function automatic axis_beat_t random_beat();
    axis_beat_t beat;
    beat.tdata = DATA_WIDTH'({$urandom(), $urandom(), $urandom()});
    beat.tlast = ($urandom_range(7) == 0);
    return beat;
  endfunction

  //////////////////////////////
  // drivers, on falling edges
  //////////////////////////////

  // source holds tvalid and beat until the transfer
  always @(negedge s_axis_clk) begin
    if (!s_axis_tvalid || s_fire) begin
      if (offered_count < offer_limit && (offer_dense || $urandom_range(99) < 60)) begin
        s_axis_tvalid <= 1'b1;
        s_axis_beat   <= random_beat();
        offered_count <= offered_count + 1;
      end else begin
        s_axis_tvalid <= 1'b0;
      end
    end
  end

  always @(negedge m_axis_clk) begin
    case (sink_mode)
      SINK_STALL: m_axis_tready <= 1'b0;
      SINK_READY: m_axis_tready <= 1'b1;
      default:    m_axis_tready <= ($urandom_range(99) < 50);
    endcase
  end

  //////////////////////////////
  // scoreboard
  //////////////////////////////

  always @(posedge s_axis_clk) begin
    s_fire <= s_axis_tvalid && s_axis_tready;
    if (s_axis_tvalid && s_axis_tready) begin
      sb_q.push_back(s_axis_beat);
      accepted_count <= accepted_count + 1;
    end
  end

  always @(posedge m_axis_clk) begin
    held_beat <= m_axis_beat;
    if (m_edges < 8) begin
      m_edges <= m_edges + 1;
    end
    if (m_axis_tvalid && m_axis_tready) begin
      assert (delivered_count < sb_q.size())
        else abort_run("ordering: beat delivered with no accepted beat outstanding");
      // tdata and tlast both compared
      assert (m_axis_beat == sb_q[delivered_count])
        else report_beat_mismatch("ordering", sb_q[delivered_count], m_axis_beat);
      delivered_count <= delivered_count + 1;
    end
  end

  //////////////////////////////
  // assertions
  //////////////////////////////

  reset_tready_low: assert property (@(posedge s_axis_clk) reset |=> !s_axis_tready)
    else abort_run("reset_idle: s_axis_tready high while reset was applied");

  // nothing crossed yet, so nothing offered on the master side
  reset_tvalid_low: assert property (@(posedge m_axis_clk)
      disable iff (m_edges < SYNC_STAGES + 1)
      (accepted_count == 0) |-> !m_axis_tvalid)
    else abort_run("reset_idle: m_axis_tvalid high before any write crossed");

  hold_valid: assert property (@(posedge m_axis_clk)
      disable iff (m_edges < SYNC_STAGES + 1)
      (m_axis_tvalid && !m_axis_tready) |=> m_axis_tvalid)
    else abort_run("hold_stable: m_axis_tvalid dropped while stalled");

  hold_beat: assert property (@(posedge m_axis_clk)
      disable iff (m_edges < SYNC_STAGES + 1)
      (m_axis_tvalid && !m_axis_tready) |=> (m_axis_beat == held_beat))
    else report_beat_mismatch("hold_stable", $sampled(held_beat), $sampled(m_axis_beat));

  fill_bound: assert property (@(posedge s_axis_clk)
      (accepted_count - delivered_count) <= FIFO_DEPTH)
    else report_count_mismatch("fill_limit", FIFO_DEPTH,
                               $sampled(accepted_count - delivered_count));

  drained_idle: assert property (@(posedge m_axis_clk) drained |-> !m_axis_tvalid)
    else abort_run("drain: m_axis_tvalid high after every beat was delivered");

  //////////////////////////////
  // test sequence
  //////////////////////////////

  // controls change after rising edges, drivers read them on falling edges
  initial begin
    void'($urandom(SEED));
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge s_axis_clk);
    @(negedge s_axis_clk);
    reset = 1'b0;

    // random valid and ready duty on both sides
    @(posedge s_axis_clk);
    offer_limit = RANDOM_BEATS;
    wait (delivered_count == RANDOM_BEATS);

    // stall the sink, then offer data every cycle
    @(posedge m_axis_clk);
    sink_mode = SINK_STALL;
    repeat (2) @(posedge m_axis_clk);
    @(posedge s_axis_clk);
    offer_dense = 1'b1;
    offer_limit = RANDOM_BEATS + FILL_BEATS;
    repeat (FILL_CYCLES) @(posedge s_axis_clk);
    @(negedge s_axis_clk);
    assert (accepted_count - delivered_count == FIFO_DEPTH)
      else report_count_mismatch("fill_limit", FIFO_DEPTH, accepted_count - delivered_count);
    assert (!s_axis_tready)
      else abort_run("fill_limit: s_axis_tready high with the FIFO full");

    // source stops after the pending beat, sink drains
    @(posedge s_axis_clk);
    offer_limit = offered_count;
    @(posedge m_axis_clk);
    sink_mode = SINK_READY;
    wait (!s_axis_tvalid && delivered_count == accepted_count);
    @(negedge m_axis_clk);
    drained = 1'b1;
    repeat (DRAIN_CYCLES) @(posedge m_axis_clk);
    @(negedge s_axis_clk);
    assert (s_axis_tready)
      else abort_run("drain: s_axis_tready still low after the FIFO drained");

    $display("RESULT: PASS");
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog: simulation did not complete in time");
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/axis_cdc_pkg.sv
hw/cdc_sync.sv
axis_fifo_async/fifo_mem.sv
axis_fifo_async/fifo_wr_ctrl.sv
axis_fifo_async/fifo_rd_ctrl.sv
axis_fifo_async/axis_fifo_async.sv
sim/tb_clock_gen.sv
sim/tb_axis_fifo_async.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, result taken from sim.log
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_axis_fifo_async \
  -f filelist.f \
  -o tb_axis_fifo_async

# tee keeps the run going on a fatal stop so the log is searched below
./obj_dir/tb_axis_fifo_async 2>&1 | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
